// File: all.f
+incdir+bench
source/heapPkg.sv
source/heapInterfaces.sv
source/requestPort.sv
source/arrayDirectory.sv
source/elementStore.sv
source/commitStage.sv
source/heapMemory.sv
bench/heapMemoryBench.sv

// File: run.sh
#!/bin/bash
# Builds the heap testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module heapMemoryBench -f all.f -o heapSim \
  && ./obj_dir/heapSim | tee sim.log \
  || { echo "Build or simulation did not complete"; exit 1; }
grep -q 'Test failures found' sim.log && { echo "Simulation reported failures"; exit 1; }
grep -q 'All tests passed!' sim.log || { echo "Simulation ended early"; exit 1; }
exit 0

// File: bench/heapModel.svh
/* Heap reference model
   Model copy of the heap state and the function that predicts out and error */

`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

int                   modelCount;                    // Arrays handed out so far
bit                   modelFlag [ARRAYS];            // Array in use
int                   modelSize [ARRAYS];
int                   modelFreed [$];                // Freed arrays, last on top
logic [DATA_BITS-1:0] modelElem [ARRAYS][LENGTH];

// Predicts one request, updates the model only when it succeeds
function automatic heapError modelRequest(input heapOp reqOp, input int arr, input int idx,
                                          input logic [DATA_BITS-1:0] value,
                                          output logic [DATA_BITS-1:0] expOut);
  logic [DATA_BITS-1:0] old;
  int                   slot;
  expOut = '0;                                       // Zero on any error
  if (reqOp == opReset) begin
    modelCount = 0;
    modelFreed.delete();
    foreach (modelFlag[i]) modelFlag[i] = 1'b0;
    return errNone;
  end
  if (reqOp == opAlloc) begin
    if (modelFreed.size() > 0) begin
      slot = modelFreed.pop_back();                  // Reuse last freed
    end else if (modelCount < ARRAYS) begin
      slot = modelCount;
      modelCount++;
    end else begin
      return errOutOfMemory;
    end
    modelFlag[slot] = 1'b1;
    modelSize[slot] = 0;                             // Fresh array is empty
    expOut = DATA_BITS'(slot);
    return errNone;
  end
  if (arr >= modelCount) return errNotAllocated;     // Highest priority
  if (!modelFlag[arr]) return errFreed;
  case (reqOp)
    opFree: begin
      modelFlag[arr] = 1'b0;
      modelFreed.push_back(arr);
    end
    opWrite: begin
      modelElem[arr][idx] = value;
      if (idx >= modelSize[arr]) modelSize[arr] = idx + 1;  // Grows up to index
      expOut = value;
    end
    opSize: expOut = DATA_BITS'(modelSize[arr]);
    opPush: begin
      if (modelSize[arr] == LENGTH) return errFull;
      modelElem[arr][modelSize[arr]] = value;
      modelSize[arr]++;
      expOut = value;                                // Input comes back
    end
    opPop: begin
      if (modelSize[arr] == 0) return errEmpty;
      modelSize[arr]--;
      expOut = modelElem[arr][modelSize[arr]];
    end
    default: begin                                   // Read, arithmetic, logic
      if (idx >= modelSize[arr]) return errOutOfBounds;
      old = modelElem[arr][idx];
      case (reqOp)
        opAdd, opAddAfter:      modelElem[arr][idx] = old + value;
        opSubtract, opSubAfter: modelElem[arr][idx] = old - value;
        opOr:                   modelElem[arr][idx] = old | value;
        opXor:                  modelElem[arr][idx] = old ^ value;
        opAnd:                  modelElem[arr][idx] = old & value;
        default:                ;                    // Read leaves it alone
      endcase
      expOut = (reqOp == opAddAfter || reqOp == opSubAfter) ? old : modelElem[arr][idx];
    end
  endcase
  return errNone;
endfunction

`endif

// File: bench/heapMemoryBench.sv
/* Heap memory testbench
   Drives the Wishbone port and compares every response with the reference model */

`default_nettype none

module heapMemoryBench import heapPkg::*; ();

  localparam int ADDRESS_BITS = 2;
  localparam int INDEX_BITS   = 2;
  localparam int DATA_BITS    = 12;
  localparam int ARRAYS       = 2 ** ADDRESS_BITS;
  localparam int LENGTH       = 2 ** INDEX_BITS;
  localparam int SEED         = 92612;
  localparam int ACK_LIMIT    = 20;                  // Cycles before giving up on ack
  localparam int ACK_LATENCY  = 4;                   // Negedges from drive edge to ack

  logic                    clock;
  logic                    resetN;
  logic                    cyc;
  logic                    stb;
  heapOp                   op;
  logic [ADDRESS_BITS-1:0] array;
  logic [INDEX_BITS-1:0]   index;
  logic [DATA_BITS-1:0]    data;
  logic                    ack;
  logic [DATA_BITS-1:0]    out;
  heapError                error;

  int                      errorCount;
  int                      checkCount;
  bit                      timedOut;                 // Set once, stops further requests
  logic [DATA_BITS-1:0]    lastOut;                  // Response seen by the master
  heapError                lastError;
  logic [DATA_BITS-1:0]    expOutQueue [$];
  heapError                expErrorQueue [$];
  logic [DATA_BITS-1:0]    pushed [LENGTH];
  heapOp                   randomOps [8];

  `include "heapModel.svh"

  heapMemory #(.ADDRESS_BITS(ADDRESS_BITS), .INDEX_BITS(INDEX_BITS),
               .DATA_BITS(DATA_BITS)) dut (
    .clock, .resetN, .cyc, .stb, .op, .array, .index, .data, .ack, .out, .error
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // ----------------------------------------------------------
  // Checking
  // ----------------------------------------------------------
  task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] want);
    checkCount++;
    if (got !== want) begin
      errorCount++;
      $display("** Error at time %0t: %s is %0h, expected %0h", $time, what, got, want);
    end
  endtask

  task automatic expectResult(input string what, input logic [DATA_BITS-1:0] wantOut,
                              input heapError wantError);
    checkValue({what, " out"}, lastOut, wantOut);
    checkValue({what, " error"}, lastError, wantError);
  endtask

  // Every ack is matched against the oldest prediction
  always @(negedge clock) begin
    if (resetN && ack) begin
      if (expOutQueue.size() == 0) begin
        errorCount++;
        $display("Ack at time %0t without any request pending", $time);
      end else begin
        checkValue("out", out, expOutQueue.pop_front());
        checkValue("error", error, expErrorQueue.pop_front());
      end
    end
  end

  // ----------------------------------------------------------
  // Bus master
  // ----------------------------------------------------------
  task automatic issueRequest(input heapOp reqOp, input int reqArray, input int reqIndex,
                              input logic [DATA_BITS-1:0] reqData);
    logic [DATA_BITS-1:0] expOut;
    heapError             expError;
    int                   waited;
    if (timedOut) return;
    expError = modelRequest(reqOp, reqArray, reqIndex, reqData, expOut);
    expOutQueue.push_back(expOut);
    expErrorQueue.push_back(expError);
    @(posedge clock);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    op    <= reqOp;
    array <= ADDRESS_BITS'(reqArray);
    index <= INDEX_BITS'(reqIndex);
    data  <= reqData;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (!ack && waited < ACK_LIMIT);
    if (!ack) begin
      timedOut = 1'b1;
      $display("Timeout: no ack within %0d cycles for %s", ACK_LIMIT, reqOp.name());
    end else begin
      checkValue("ack latency", waited, ACK_LATENCY);
      lastOut   = out;
      lastError = error;
      @(posedge clock);                              // Edge that samples ack
      cyc <= 1'b0;
      stb <= 1'b0;
      @(negedge clock);
      checkValue("ack width", ack, 1'b0);            // Single cycle only
    end
  endtask

  // ----------------------------------------------------------
  // Test sequences
  // ----------------------------------------------------------
  initial begin
    logic [DATA_BITS-1:0] value;
    void'($urandom(SEED));
    errorCount = 0;
    checkCount = 0;
    timedOut   = 1'b0;
    randomOps  = '{opAdd, opAddAfter, opSubtract, opSubAfter, opOr, opXor, opAnd, opRead};
    void'(modelRequest(opReset, 0, 0, '0, value));
    resetN <= 1'b0;
    cyc    <= 1'b0;
    stb    <= 1'b0;
    op     <= opReset;
    array  <= '0;
    index  <= '0;
    data   <= '0;
    repeat (2) @(posedge clock);
    resetN <= 1'b1;
    repeat (3) begin                                 // Quiet bus after reset
      @(negedge clock);
      checkValue("idle ack", ack, 1'b0);
      checkValue("idle out", out, '0);
      checkValue("idle error", error, errNone);
    end

    // Allocation order, exhaustion, reuse and heap reset
    for (int i = 0; i < ARRAYS; i++) begin
      issueRequest(opAlloc, 0, 0, '0);
      expectResult("alloc order", DATA_BITS'(i), errNone);
    end
    issueRequest(opAlloc, 0, 0, '0);
    expectResult("alloc when full", '0, errOutOfMemory);
    issueRequest(opFree, 1, 0, '0);
    issueRequest(opFree, 2, 0, '0);
    issueRequest(opAlloc, 0, 0, '0);
    expectResult("reuse last freed", 2, errNone);
    issueRequest(opAlloc, 0, 0, '0);
    expectResult("reuse first freed", 1, errNone);
    issueRequest(opReset, 0, 0, '0);
    issueRequest(opAlloc, 0, 0, '0);
    expectResult("alloc after reset", 0, errNone);

    // Access checks leave the state alone
    issueRequest(opAlloc, 0, 0, '0);
    issueRequest(opFree, 1, 0, '0);
    issueRequest(opFree, 1, 0, '0);
    expectResult("double free", '0, errFreed);
    issueRequest(opRead, 1, 0, '0);
    expectResult("read freed", '0, errFreed);
    issueRequest(opRead, 3, 0, '0);
    expectResult("beyond count", '0, errNotAllocated);
    issueRequest(opAlloc, 0, 0, '0);
    expectResult("single freed entry", 1, errNone);
    issueRequest(opAlloc, 0, 0, '0);
    expectResult("freed stack empty", 2, errNone);

    // Push until full, pop until empty
    for (int i = 0; i < LENGTH; i++) begin
      pushed[i] = DATA_BITS'($urandom);
      issueRequest(opPush, 0, 0, pushed[i]);
      expectResult("push echo", pushed[i], errNone);
    end
    issueRequest(opSize, 0, 0, '0);
    expectResult("size after pushes", LENGTH, errNone);
    issueRequest(opPush, 0, 0, 12'h5a5);
    expectResult("push full", '0, errFull);
    for (int i = LENGTH - 1; i >= 0; i--) begin
      issueRequest(opPop, 0, 0, '0);
      expectResult("pop order", pushed[i], errNone);
    end
    issueRequest(opPop, 0, 0, '0);
    expectResult("pop empty", '0, errEmpty);

    // Write grows the size, read stays inside it
    issueRequest(opWrite, 1, 0, DATA_BITS'($urandom));
    issueRequest(opSize, 1, 0, '0);
    expectResult("size after write 0", 1, errNone);
    issueRequest(opWrite, 1, 2, DATA_BITS'($urandom));
    issueRequest(opSize, 1, 0, '0);
    expectResult("size after write 2", 3, errNone);
    issueRequest(opRead, 1, 3, '0);
    expectResult("read past size", '0, errOutOfBounds);
    issueRequest(opWrite, 1, 1, DATA_BITS'($urandom));
    issueRequest(opRead, 1, 1, '0);

    // Random in-place operations on fully written arrays
    issueRequest(opReset, 0, 0, '0);
    for (int a = 0; a < ARRAYS; a++) begin
      issueRequest(opAlloc, 0, 0, '0);
      for (int i = 0; i < LENGTH; i++) begin
        issueRequest(opWrite, a, i, DATA_BITS'($urandom));
      end
    end
    repeat (200) begin
      issueRequest(randomOps[$urandom_range(7)], $urandom_range(ARRAYS - 1),
                   $urandom_range(LENGTH - 1), DATA_BITS'($urandom));
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timedOut);
    if (errorCount == 0 && !timedOut) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/heapMemory.sv
/* Heap memory top level
   Array heap behind a Wishbone classic port, directory and element
   store side by side with a commit stage after them */

`default_nettype none

module heapMemory import heapPkg::*; #(
  parameter int ADDRESS_BITS = 2,                // 2**ADDRESS_BITS arrays
  parameter int INDEX_BITS   = 2,                // 2**INDEX_BITS elements each
  parameter int DATA_BITS    = 12                // Element width
) (
  input  wire logic                    clock,
  input  wire logic                    resetN,
  input  wire logic                    cyc,
  input  wire logic                    stb,
  input  wire heapOp                   op,
  input  wire logic [ADDRESS_BITS-1:0] array,
  input  wire logic [INDEX_BITS-1:0]   index,
  input  wire logic [DATA_BITS-1:0]    data,
  output logic                         ack,
  output logic [DATA_BITS-1:0]         out,
  output heapError                     error
);

  localparam int LENGTH = 2 ** INDEX_BITS;

  logic [DATA_BITS-1:0] row [LENGTH];            // Fetched row, store to commit

  // ----------------------------------------------------------
  // Internal channels
  // ----------------------------------------------------------
  heapRequestIf #(.ADDRESS_BITS(ADDRESS_BITS), .INDEX_BITS(INDEX_BITS),
                  .DATA_BITS(DATA_BITS)) request ();
  directoryVerdictIf #(.ADDRESS_BITS(ADDRESS_BITS), .INDEX_BITS(INDEX_BITS)) verdict ();
  elementWriteIf #(.ADDRESS_BITS(ADDRESS_BITS), .INDEX_BITS(INDEX_BITS),
                   .DATA_BITS(DATA_BITS)) write ();

  requestPort #(.ADDRESS_BITS(ADDRESS_BITS), .INDEX_BITS(INDEX_BITS),
                .DATA_BITS(DATA_BITS)) port (
    .clock, .resetN, .cyc, .stb, .op, .array, .index, .data,
    .ack, .request(request.source)
  );

  arrayDirectory #(.ADDRESS_BITS(ADDRESS_BITS), .INDEX_BITS(INDEX_BITS)) directory (
    .clock, .resetN, .request(request.sink), .verdict(verdict.source)
  );

  elementStore #(.ADDRESS_BITS(ADDRESS_BITS), .INDEX_BITS(INDEX_BITS),
                 .DATA_BITS(DATA_BITS)) store (
    .clock, .request(request.sink), .write(write.sink), .row
  );

  commitStage #(.ADDRESS_BITS(ADDRESS_BITS), .INDEX_BITS(INDEX_BITS),
                .DATA_BITS(DATA_BITS)) commit (
    .clock, .resetN, .request(request.sink), .verdict(verdict.sink), .row,
    .write(write.source), .ack, .out, .error
  );

endmodule

`default_nettype wire

// File: source/commitStage.sv
/* Commit stage
   Picks the element, runs the arithmetic or logic op, writes it
   back and registers out, error and ack */

`default_nettype none

module commitStage import heapPkg::*; #(
  parameter int ADDRESS_BITS = 2,
  parameter int INDEX_BITS   = 2,
  parameter int DATA_BITS    = 12
) (
  input  wire logic                 clock,
  input  wire logic                 resetN,
  heapRequestIf.sink                request,
  directoryVerdictIf.sink           verdict,
  input  wire logic [DATA_BITS-1:0] row [2**INDEX_BITS],
  elementWriteIf.source             write,
  output logic                      ack,
  output logic [DATA_BITS-1:0]      out,
  output heapError                  error
);

  logic [DATA_BITS-1:0] element;                 // Current element value
  logic [DATA_BITS-1:0] result;                  // Value to store back
  logic [DATA_BITS-1:0] outValue;                // Out when no error
  logic                 storeBack;               // Op changes the element
  logic                 accepted;                // Verdict without error

  assign accepted = verdict.valid && verdict.error == errNone;
  assign element  = row[verdict.effectiveIndex];

  // ----------------------------------------------------------
  // Operation
  // ----------------------------------------------------------
  always_comb begin
    case (request.op)
      opAdd, opAddAfter:      result = element + request.data;
      opSubtract, opSubAfter: result = element - request.data;
      opOr:                   result = element | request.data;
      opXor:                  result = element ^ request.data;
      opAnd:                  result = element & request.data;
      default:                result = request.data;  // Write and Push
    endcase
  end

  // Response value and write-back select
  always_comb begin
    outValue  = '0;                              // Reset and Free give zero
    storeBack = 1'b0;
    case (request.op)
      opAlloc: outValue[ADDRESS_BITS-1:0] = verdict.allocatedArray;
      opSize:  outValue[INDEX_BITS:0]     = verdict.size;
      opRead, opPop: outValue = element;
      opWrite, opPush: begin
        outValue  = request.data;                // Echo the input
        storeBack = 1'b1;
      end
      opAddAfter, opSubAfter: begin
        outValue  = element;                     // Old value
        storeBack = 1'b1;
      end
      opAdd, opSubtract, opOr, opXor, opAnd: begin
        outValue  = result;                      // New value
        storeBack = 1'b1;
      end
      default: ;
    endcase
  end

  // Element write, taken by the store at E2
  assign write.write = accepted && storeBack;
  assign write.array = request.array;
  assign write.index = verdict.effectiveIndex;
  assign write.value = result;

  // ----------------------------------------------------------
  // Response at E2
  // ----------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      ack   <= 1'b0;
      out   <= '0;
      error <= errNone;
    end else begin
      ack <= verdict.valid;                      // One cycle per request
      if (verdict.valid) begin
        out   <= (verdict.error == errNone) ? outValue : '0;
        error <= verdict.error;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/elementStore.sv
/* Element store
   Element memory of all arrays, registered whole-row read
   and single element write-back */

`default_nettype none

module elementStore #(
  parameter int ADDRESS_BITS = 2,
  parameter int INDEX_BITS   = 2,
  parameter int DATA_BITS    = 12
) (
  input  wire logic            clock,
  heapRequestIf.sink           request,
  elementWriteIf.sink          write,
  output logic [DATA_BITS-1:0] row [2**INDEX_BITS]   // Row of requested array
);

  localparam int ARRAYS = 2 ** ADDRESS_BITS;
  localparam int LENGTH = 2 ** INDEX_BITS;

  logic [DATA_BITS-1:0] memory [ARRAYS][LENGTH];     // Fixed block per array

  // ----------------------------------------------------------
  // Row fetch at E1
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (request.valid) begin
      row <= memory[request.array];                  // Whole row in one go
    end
  end

  // Write-back lands at E2, before any later fetch
  always_ff @(posedge clock) begin
    if (write.write) begin
      memory[write.array][write.index] <= write.value;
    end
  end

endmodule

`default_nettype wire

// File: source/arrayDirectory.sv
/* Array directory
   Tracks allocation flags, array sizes and the freed stack,
   checks every request and reports a verdict with the element index */

`default_nettype none

module arrayDirectory import heapPkg::*; #(
  parameter int ADDRESS_BITS = 2,
  parameter int INDEX_BITS   = 2
) (
  input  wire logic          clock,
  input  wire logic          resetN,
  heapRequestIf.sink         request,
  directoryVerdictIf.source  verdict
);

  localparam int ARRAYS = 2 ** ADDRESS_BITS;
  localparam logic [ADDRESS_BITS:0] MAX_COUNT = {1'b1, {ADDRESS_BITS{1'b0}}}; // All arrays used
  localparam logic [INDEX_BITS:0]   MAX_SIZE  = {1'b1, {INDEX_BITS{1'b0}}};   // Array full

  logic [ADDRESS_BITS:0]   arrayCount;           // Arrays handed out so far
  logic [ARRAYS-1:0]       allocated;            // Per array in use flag
  logic [INDEX_BITS:0]     sizes [ARRAYS];       // Per array element count
  logic [ADDRESS_BITS-1:0] freedStack [ARRAYS];  // Freed arrays, last on top
  logic [ADDRESS_BITS:0]   freedTop;             // Entries on freed stack
  logic [ADDRESS_BITS-1:0] freedSlot;            // Top entry position

  logic [INDEX_BITS:0]     currentSize;          // Size of addressed array
  logic                    reuseFreed;           // Alloc from freed stack
  logic [ADDRESS_BITS-1:0] newArray;             // Array Alloc would return
  logic [INDEX_BITS-1:0]   effIndex;
  heapError                checkError;
  logic                    commit;               // Apply bookkeeping now

  assign currentSize = sizes[request.array];
  assign freedSlot   = ADDRESS_BITS'(freedTop - 1'b1);
  assign reuseFreed  = freedTop != '0;
  assign newArray    = reuseFreed ? freedStack[freedSlot] : arrayCount[ADDRESS_BITS-1:0];
  assign commit      = request.valid && checkError == errNone;

  // ----------------------------------------------------------
  // Error checks in fixed priority
  // ----------------------------------------------------------
  always_comb begin
    checkError = errNone;
    case (request.op)
      opReset: checkError = errNone;             // Always allowed
      opAlloc: begin
        if (!reuseFreed && arrayCount == MAX_COUNT) begin
          checkError = errOutOfMemory;
        end
      end
      default: begin
        if ({1'b0, request.array} >= arrayCount) begin
          checkError = errNotAllocated;
        end else if (!allocated[request.array]) begin
          checkError = errFreed;
        end else begin
          case (request.op)
            opRead, opAdd, opAddAfter, opSubtract, opSubAfter, opOr, opXor, opAnd: begin
              if ({1'b0, request.index} >= currentSize) checkError = errOutOfBounds;
            end
            opPush:  if (currentSize == MAX_SIZE) checkError = errFull;
            opPop:   if (currentSize == '0) checkError = errEmpty;
            default: checkError = errNone;
          endcase
        end
      end
    endcase
  end

  // Element touched by the request
  always_comb begin
    case (request.op)
      opPush:  effIndex = currentSize[INDEX_BITS-1:0];       // Slot past the end
      opPop:   effIndex = INDEX_BITS'(currentSize - 1'b1);   // Last element
      default: effIndex = request.index;
    endcase
  end

  // ----------------------------------------------------------
  // Bookkeeping and verdict at E1
  // ----------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      arrayCount    <= '0;
      allocated     <= '0;
      freedTop      <= '0;
      verdict.valid <= 1'b0;
      verdict.error <= errNone;
      for (int i = 0; i < ARRAYS; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      verdict.valid <= request.valid;
      if (request.valid) verdict.error <= checkError;
      if (commit) begin
        case (request.op)
          opReset: begin                         // Empty heap again
            arrayCount <= '0;
            freedTop   <= '0;
            allocated  <= '0;
          end
          opAlloc: begin
            if (reuseFreed) freedTop <= freedTop - 1'b1;
            else arrayCount <= arrayCount + 1'b1;
            allocated[newArray] <= 1'b1;
            sizes[newArray]     <= '0;           // Starts empty
          end
          opFree: begin
            allocated[request.array] <= 1'b0;
            freedTop                 <= freedTop + 1'b1;
          end
          opWrite: begin                         // Grow up to written index
            if ({1'b0, request.index} >= currentSize) begin
              sizes[request.array] <= {1'b0, request.index} + 1'b1;
            end
          end
          opPush:  sizes[request.array] <= currentSize + 1'b1;
          opPop:   sizes[request.array] <= currentSize - 1'b1;
          default: ;
        endcase
      end
    end
  end

  // Freed stack entries and verdict payload
  always_ff @(posedge clock) begin
    if (commit && request.op == opFree) begin
      freedStack[freedTop[ADDRESS_BITS-1:0]] <= request.array;
    end
    if (request.valid) begin
      verdict.effectiveIndex <= effIndex;
      verdict.size           <= currentSize;     // Size before this request
      verdict.allocatedArray <= newArray;
    end
  end

endmodule

`default_nettype wire

// File: source/requestPort.sv
/* Request port
   Wishbone classic slave, takes one request at a time and
   broadcasts it to the heap with a single valid pulse */

`default_nettype none

module requestPort import heapPkg::*; #(
  parameter int ADDRESS_BITS = 2,
  parameter int INDEX_BITS   = 2,
  parameter int DATA_BITS    = 12
) (
  input  wire logic                    clock,
  input  wire logic                    resetN,
  input  wire logic                    cyc,
  input  wire logic                    stb,
  input  wire heapOp                   op,
  input  wire logic [ADDRESS_BITS-1:0] array,
  input  wire logic [INDEX_BITS-1:0]   index,
  input  wire logic [DATA_BITS-1:0]    data,
  input  wire logic                    ack,      // From commit stage
  heapRequestIf.source                 request
);

  logic busy;                                    // Request in flight
  logic accept;                                  // Start of a new request

  assign accept = cyc && stb && !busy;           // Held stb ignored while busy

  // ----------------------------------------------------------
  // Control, busy until the edge that sees ack
  // ----------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      busy          <= 1'b0;
      request.valid <= 1'b0;
    end else begin
      request.valid <= accept;                   // Single pulse after E0
      if (accept) begin
        busy <= 1'b1;
      end else if (ack) begin
        busy <= 1'b0;                            // Free again at E3
      end
    end
  end

  // Request fields, held until the next acceptance
  always_ff @(posedge clock) begin
    if (accept) begin
      request.op    <= op;
      request.array <= array;
      request.index <= index;
      request.data  <= data;
    end
  end

endmodule

`default_nettype wire

// File: source/heapInterfaces.sv
/* Heap internal interfaces
   Request broadcast, directory verdict and element write-back channels */

`default_nettype none

// Latched bus request, valid pulses once per accepted request
interface heapRequestIf import heapPkg::*; #(
  parameter int ADDRESS_BITS = 2,
  parameter int INDEX_BITS   = 2,
  parameter int DATA_BITS    = 12
);
  logic                    valid;         // One cycle per request
  heapOp                   op;            // Stable until next pulse
  logic [ADDRESS_BITS-1:0] array;
  logic [INDEX_BITS-1:0]   index;
  logic [DATA_BITS-1:0]    data;

  modport source (output valid, op, array, index, data);
  modport sink   (input  valid, op, array, index, data);
endinterface

// Bookkeeping result of the directory, one cycle after the request
interface directoryVerdictIf import heapPkg::*; #(
  parameter int ADDRESS_BITS = 2,
  parameter int INDEX_BITS   = 2
);
  logic                    valid;         // One cycle pulse
  heapError                error;         // Winning error by priority
  logic [INDEX_BITS-1:0]   effectiveIndex; // Element to touch
  logic [INDEX_BITS:0]     size;          // Size before the request
  logic [ADDRESS_BITS-1:0] allocatedArray; // Result of Alloc

  modport source (output valid, error, effectiveIndex, size, allocatedArray);
  modport sink   (input  valid, error, effectiveIndex, size, allocatedArray);
endinterface

// Single element write into the element store
interface elementWriteIf #(
  parameter int ADDRESS_BITS = 2,
  parameter int INDEX_BITS   = 2,
  parameter int DATA_BITS    = 12
);
  logic                    write;         // Write strobe
  logic [ADDRESS_BITS-1:0] array;
  logic [INDEX_BITS-1:0]   index;
  logic [DATA_BITS-1:0]    value;

  modport source (output write, array, index, value);
  modport sink   (input  write, array, index, value);
endinterface

`default_nettype wire

// File: source/heapPkg.sv
/* Heap package
   Operation and error codes shared by the heap design and its testbench */

`default_nettype none

package heapPkg;

  // ----------------------------------------------------------
  // Operations
  // ----------------------------------------------------------
  typedef enum logic [3:0] {
    opReset    = 4'd0,                    // Clear the whole heap
    opAlloc    = 4'd1,                    // Take a new or freed array
    opFree     = 4'd2,                    // Return array for reuse
    opWrite    = 4'd3,                    // Store element, may grow size
    opRead     = 4'd4,                    // Fetch element inside bounds
    opSize     = 4'd5,                    // Current array size
    opPush     = 4'd6,                    // Append at the end
    opPop      = 4'd7,                    // Remove from the end
    opAdd      = 4'd8,                    // Add, new value out
    opAddAfter = 4'd9,                    // Add, old value out
    opSubtract = 4'd10,                   // Subtract, new value out
    opSubAfter = 4'd11,                   // Subtract, old value out
    opOr       = 4'd12,                   // Bitwise or in place
    opXor      = 4'd13,                   // Bitwise xor in place
    opAnd      = 4'd14                    // Bitwise and in place
  } heapOp;

  // ----------------------------------------------------------
  // Errors, listed roughly in check order
  // ----------------------------------------------------------
  typedef enum logic [2:0] {
    errNone         = 3'd0,               // Request done
    errNotAllocated = 3'd1,               // Array number beyond count
    errFreed        = 3'd2,               // Array sits on freed stack
    errOutOfBounds  = 3'd3,               // Index at or past size
    errFull         = 3'd4,               // Push into full array
    errEmpty        = 3'd5,               // Pop from empty array
    errOutOfMemory  = 3'd6                // No array left to allocate
  } heapError;

endpackage

`default_nettype wire
